// ==== Makefile ====
# Verilator build and run of the platform controller testbench

TOP = platform_ctrl_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// ==== tests/platform_apb_tasks.svh ====
`ifndef platform_apb_tasks_svh
`define platform_apb_tasks_svh

// Run-wide error and test bookkeeping
int err_cnt = 0;
int test_errs = 0;
int test_cnt = 0;
int test_fails = 0;

// Report a failed check with its time
function automatic void log_error(string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
endfunction

// Compare one value against the expected one
function automatic void check_eq(string what, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else log_error($sformatf("%s is 0x%0h, expected 0x%0h", what, got, exp));
endfunction

function automatic void start_test();
    test_errs = err_cnt;
endfunction

// One line per finished test
function automatic void end_test(string name);
    test_cnt++;
    if (err_cnt == test_errs) begin
        $display("Test %0d %s: passed", test_cnt, name);
    end else begin
        test_fails++;
        $display("Test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - test_errs);
    end
endfunction

// Drive point, 2 ns after the rising edge
task automatic step();
    @(posedge clk125);
    #2;
endtask

// Zero-wait APB transfer
// Response sampled mid access phase
task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic slverr);
    step();
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    step();
    apb_req.penable = 1'b1;
    @(negedge clk125);
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_eq("pready", 32'(apb_rsp.pready), 32'd1);
    // Access ends on this edge
    step();
    apb_req = '0;
endtask

task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    logic        slverr;
    apb_xfer(1'b1, addr, wdata, unused_rd, slverr);
    check_eq($sformatf("pslverr on write to 0x%02h", addr), 32'(slverr), 32'd0);
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic slverr;
    apb_xfer(1'b0, addr, 32'd0, rdata, slverr);
    check_eq($sformatf("pslverr on read of 0x%02h", addr), 32'(slverr), 32'd0);
endtask

`endif

// ==== tests/platform_ctrl_tb.sv ====
module platform_ctrl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import platform_pkg::*;

    // Slot clock wait is at most three half periods (~11700)
    // Everything else stays under 1500 cycles
    localparam int max_cycles = 20000;

    logic                 clk125;
    logic                 sys_rst_n;
    apb_req_t             apb_req;
    apb_rsp_t             apb_rsp;
    logic                 voltage_alert;
    logic                 power_failure_n;
    logic [num_slots-1:0] slot_present_n;
    logic [4:0]           ltssm;
    logic [num_slots-1:0] slot_clk;
    logic [num_slots-1:0] slot_clk_oe;
    logic [num_slots-1:0] clk_req_pull;
    logic [2:0]           prog_led_n;
    logic [num_cams-1:0]  cam_trigger;

    // Stimulus and expected values
    logic [num_slots-1:0] pres_n_rst;
    logic [num_slots-1:0] pres_exp;
    logic [31:0]          rd;
    logic                 err_flag;
    logic [1:0]           led_val;
    logic [1:0]           led_exp;
    logic [num_cams-1:0]  mask;
    int                   trig_n;
    int                   wait_cnt;
    int                   cycle_cnt = 0;

    `include "platform_apb_tasks.svh"

    platform_ctrl_top dut0 (
        .clk125          (clk125),
        .sys_rst_n       (sys_rst_n),
        .apb_req         (apb_req),
        .voltage_alert   (voltage_alert),
        .power_failure_n (power_failure_n),
        .slot_present_n  (slot_present_n),
        .ltssm           (ltssm),
        .apb_rsp         (apb_rsp),
        .slot_clk        (slot_clk),
        .slot_clk_oe     (slot_clk_oe),
        .clk_req_pull    (clk_req_pull),
        .prog_led_n      (prog_led_n),
        .cam_trigger     (cam_trigger)
    );

    // 50 MHz bench clock
    initial begin
        clk125 = 1'b0;
        forever #10 clk125 = ~clk125;
    end

    ////////////////////////////////////////////////////////////
    // Always-on checks
    ////////////////////////////////////////////////////////////

    // Absent slots never see the sync clock
    assert property (@(posedge clk125) disable iff (!sys_rst_n)
                     (slot_clk & ~pres_exp) == '0)
    else log_error("sync clock seen on an absent slot");

    // Present slots switch together
    assert property (@(posedge clk125) disable iff (!sys_rst_n)
                     slot_clk == '0 || slot_clk == pres_exp)
    else log_error("present slots are out of phase");

    // Enables either off or the full presence pattern
    assert property (@(posedge clk125) disable iff (!sys_rst_n)
                     slot_clk_oe == '0 || slot_clk_oe == pres_exp)
    else log_error("slot_clk_oe does not match presence");

    assert property (@(posedge clk125) !sys_rst_n |-> cam_trigger == '0)
    else log_error("camera trigger active in reset");

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Mask for len cycles, then all low
    task automatic check_pulse(input logic [num_cams-1:0] exp_mask, input int len);
        for (int i = 0; i < len; i++) begin
            @(negedge clk125);
            check_eq($sformatf("cam_trigger in pulse cycle %0d", i),
                     32'(cam_trigger), 32'(exp_mask));
        end
        @(negedge clk125);
        check_eq("cam_trigger after pulse", 32'(cam_trigger), 32'd0);
    endtask

    task automatic check_link(input logic [4:0] state, input logic up);
        logic [31:0] status;
        step();
        ltssm = state;
        @(negedge clk125);
        check_eq($sformatf("link led for ltssm %b", state), 32'(prog_led_n[0]), 32'(!up));
        apb_read(reg_status, status);
        check_eq($sformatf("link status for ltssm %b", state), 32'(status[2]), 32'(up));
    endtask

    // Run limit
    initial begin
        while (cycle_cnt < max_cycles) begin
            @(posedge clk125);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("Finished with errors");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(32'h89c45d13));
        // Slot 0 always fitted, last slot always empty
        pres_n_rst = num_slots'($urandom);
        pres_n_rst[0] = 1'b0;
        pres_n_rst[num_slots-1] = 1'b1;
        pres_exp = ~pres_n_rst;
        sys_rst_n = 1'b0;
        apb_req = '0;
        voltage_alert = 1'b0;
        power_failure_n = 1'b1;
        slot_present_n = pres_n_rst;
        ltssm = 5'b00000;

        // Reset values, then slot release
        start_test();
        repeat (10) begin
            step();
            check_eq("cam_trigger in reset", 32'(cam_trigger), 32'd0);
            check_eq("slot_clk_oe in reset", 32'(slot_clk_oe), 32'd0);
            check_eq("user leds in reset", 32'(prog_led_n[2:1]), 32'd3);
        end
        sys_rst_n = 1'b1;
        repeat (20) begin
            step();
            check_eq("slot_clk_oe before release", 32'(slot_clk_oe), 32'd0);
        end
        repeat (20) step();
        check_eq("slot_clk_oe after release", 32'(slot_clk_oe), 32'(pres_exp));
        end_test("reset_outputs");

        // Register access
        start_test();
        apb_read(reg_id, rd);
        check_eq("id register", rd, platform_id);
        apb_read(reg_trig_len, rd);
        check_eq("trig_len after reset", rd, 32'd100);
        led_val = 2'($urandom);
        led_exp = ~led_val;
        apb_write(reg_led, 32'(led_val));
        apb_read(reg_led, rd);
        check_eq("led register", rd, 32'(led_val));
        check_eq("user leds", 32'(prog_led_n[2:1]), 32'(led_exp));
        apb_xfer(1'b0, 8'h18, 32'd0, rd, err_flag);
        check_eq("pslverr on read of 0x18", 32'(err_flag), 32'd1);
        apb_xfer(1'b1, 8'h18, 32'd0, rd, err_flag);
        check_eq("pslverr on write to 0x18", 32'(err_flag), 32'd1);
        // No alarms and link down, so status reads zero
        apb_read(reg_status, rd);
        check_eq("status before write", rd, 32'd0);
        apb_write(reg_status, 32'hFFFF_FFFF);
        apb_read(reg_status, rd);
        check_eq("status after write", rd, 32'd0);
        end_test("register_access");

        // Short glitch must not pass the debouncer
        start_test();
        fork
            begin
                step();
                voltage_alert = 1'b1;
                repeat (10) step();
                voltage_alert = 1'b0;
            end
            repeat (15) begin
                apb_read(reg_status, rd);
                check_eq("status alert during glitch", 32'(rd[0]), 32'd0);
            end
        join
        voltage_alert = 1'b1;
        repeat (40) step();
        apb_read(reg_status, rd);
        check_eq("status alert held", 32'(rd[1:0]), 32'd1);
        power_failure_n = 1'b0;
        repeat (40) step();
        apb_read(reg_status, rd);
        check_eq("status power failure held", 32'(rd[1:0]), 32'd3);
        voltage_alert = 1'b0;
        power_failure_n = 1'b1;
        repeat (40) step();
        apb_read(reg_status, rd);
        check_eq("status alarms cleared", 32'(rd[2:0]), 32'd0);
        end_test("debouncing");

        // Slot clocks, straps now flipped
        start_test();
        slot_present_n = pres_n_rst ^ {num_slots{1'b1}};
        wait_cnt = 0;
        while (slot_clk == '0 && wait_cnt < 2 * sync_half_period) begin
            @(negedge clk125);
            wait_cnt++;
        end
        assert (slot_clk != '0)
        else log_error("present slots never saw the sync clock");
        check_eq("slot_clk high phase", 32'(slot_clk), 32'(pres_exp));
        // Length of the high phase in cycles
        wait_cnt = 0;
        while (slot_clk != '0 && wait_cnt < 2 * sync_half_period) begin
            @(negedge clk125);
            wait_cnt++;
        end
        check_eq("sync half period", 32'(wait_cnt), 32'(sync_half_period));
        check_eq("clk_req_pull", 32'(clk_req_pull), 32'(pres_exp));
        check_eq("slot_clk_oe", 32'(slot_clk_oe), 32'(pres_exp));
        apb_read(reg_presence, rd);
        check_eq("presence register", rd, 32'(pres_exp));
        end_test("slot_clocks");

        start_test();
        check_link(5'b01111, 1'b1);
        check_link(5'b10101, 1'b1);
        check_link(5'b00010, 1'b0);
        end_test("link_led");

        // One-shot, then a restart mid pulse
        start_test();
        trig_n = $urandom_range(40, 5);
        apb_write(reg_trig_len, 32'(trig_n));
        apb_read(reg_trig_len, rd);
        check_eq("trig_len register", rd, 32'(trig_n));
        mask = num_cams'($urandom_range(15, 1));
        apb_write(reg_trig_fire, 32'(mask));
        check_pulse(mask, trig_n);
        mask = num_cams'($urandom_range(15, 1));
        apb_write(reg_trig_fire, 32'(mask));
        for (int i = 0; i < trig_n / 2; i++) begin
            @(negedge clk125);
            check_eq("cam_trigger before restart", 32'(cam_trigger), 32'(mask));
        end
        mask = num_cams'($urandom_range(15, 1));
        apb_write(reg_trig_fire, 32'(mask));
        check_pulse(mask, trig_n);
        end_test("camera_triggers");

        $display("%0d tests, %0d failed, %0d errors", test_cnt, test_fails, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== verilog/input_debouncer.sv ====
module input_debouncer (
    input  logic                             clk125,
    input  logic                             sys_rst_n,
    input  logic [platform_pkg::num_alarms-1:0] raw,
    output logic [platform_pkg::num_alarms-1:0] clean
);

    import platform_pkg::*;

    // Per-bit sample history, newest sample in bit 0
    logic [num_alarms-1:0][debounce_len-1:0] hist;

    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            hist  <= '0;
            clean <= '0;
        end else begin
            for (int i = 0; i < num_alarms; i++) begin
                // Shift in the raw level
                hist[i] <= {hist[i][debounce_len-2:0], raw[i]};

                // Flip only on a full run of one level
                // Anything mixed keeps the last value
                if (hist[i] == {debounce_len{1'b1}}) begin
                    clean[i] <= 1'b1;
                end else if (hist[i] == {debounce_len{1'b0}}) begin
                    clean[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== verilog/platform_ctrl_top.sv ====
module platform_ctrl_top (
    input  logic                            clk125,
    input  logic                            sys_rst_n,
    input  platform_pkg::apb_req_t          apb_req,
    input  logic                            voltage_alert,
    input  logic                            power_failure_n,
    input  logic [platform_pkg::num_slots-1:0] slot_present_n,
    input  logic [4:0]                      ltssm,
    output platform_pkg::apb_rsp_t          apb_rsp,
    output logic [platform_pkg::num_slots-1:0] slot_clk,
    output logic [platform_pkg::num_slots-1:0] slot_clk_oe,
    output logic [platform_pkg::num_slots-1:0] clk_req_pull,
    output logic [2:0]                      prog_led_n,
    output logic [platform_pkg::num_cams-1:0]  cam_trigger
);

    import platform_pkg::*;

    // Reset sequencing
    logic core_rst_n;
    logic slot_release;

    // Raw and debounced alarms
    logic [num_alarms-1:0] alarm_raw;
    logic [num_alarms-1:0] alarms;

    // Latched board presence
    logic [num_slots-1:0] presence;

    // Power failure pin is active low
    assign alarm_raw = {~power_failure_n, voltage_alert};

    reset_sequencer u_rst_seq (
        .clk125       (clk125),
        .sys_rst_n    (sys_rst_n),
        .core_rst_n   (core_rst_n),
        .slot_release (slot_release)
    );

    input_debouncer u_debounce (
        .clk125    (clk125),
        .sys_rst_n (sys_rst_n),
        .raw       (alarm_raw),
        .clean     (alarms)
    );

    // Slot straps and sync clock share the backplane pins
    slot_clock_manager u_slot_clk (
        .clk125         (clk125),
        .core_rst_n     (core_rst_n),
        .slot_release   (slot_release),
        .slot_present_n (slot_present_n),
        .presence       (presence),
        .slot_clk       (slot_clk),
        .slot_clk_oe    (slot_clk_oe),
        .clk_req_pull   (clk_req_pull)
    );

    platform_regs u_regs (
        .clk125      (clk125),
        .sys_rst_n   (sys_rst_n),
        .apb_req     (apb_req),
        .alarms      (alarms),
        .presence    (presence),
        .ltssm       (ltssm),
        .apb_rsp     (apb_rsp),
        .prog_led_n  (prog_led_n),
        .cam_trigger (cam_trigger)
    );

endmodule

// ==== verilog/platform_pkg.sv ====
package platform_pkg;

    ////////////////////////////////////////////////////////////
    // Board sizing
    ////////////////////////////////////////////////////////////

    // Peripheral slots on the backplane
    localparam int num_slots = 7;

    // Camera trigger outputs
    localparam int num_cams = 4;

    // Alarm inputs, bit 0 voltage alert, bit 1 power failure
    localparam int num_alarms = 2;

    ////////////////////////////////////////////////////////////
    // Timing constants, all in clk125 cycles
    ////////////////////////////////////////////////////////////

    // Stable samples before a debounced bit flips (200 ns)
    localparam int debounce_len = 25;

    // Settle delay after the reset synchronizer
    localparam int settle_cycles = 25;
    localparam int settle_cnt_w = $clog2(settle_cycles + 1);

    // 125 MHz / (2 * 3906) gives roughly 16 kHz
    localparam int sync_half_period = 3906;
    localparam int sync_cnt_w = $clog2(sync_half_period);

    // Default one-shot length after reset
    localparam logic [15:0] trig_len_rst = 16'd100;

    // LTSSM encodings that count as link up
    localparam logic [4:0] ltssm_l0 = 5'b01111;
    localparam logic [4:0] ltssm_l0s = 5'b10101;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    // Read-only ID word, ASCII "PLC1"
    localparam logic [31:0] platform_id = 32'h504C_4331;

    localparam logic [7:0] reg_id = 8'h00;
    localparam logic [7:0] reg_led = 8'h04;
    localparam logic [7:0] reg_status = 8'h08;
    localparam logic [7:0] reg_presence = 8'h0C;
    localparam logic [7:0] reg_trig_fire = 8'h10;
    localparam logic [7:0] reg_trig_len = 8'h14;

    // APB request from the host
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// ==== verilog/platform_regs.sv ====
module platform_regs (
    input  logic                             clk125,
    input  logic                             sys_rst_n,
    input  platform_pkg::apb_req_t           apb_req,
    input  logic [platform_pkg::num_alarms-1:0] alarms,
    input  logic [platform_pkg::num_slots-1:0]  presence,
    input  logic [4:0]                       ltssm,
    output platform_pkg::apb_rsp_t           apb_rsp,
    output logic [2:0]                       prog_led_n,
    output logic [platform_pkg::num_cams-1:0]   cam_trigger
);

    import platform_pkg::*;

    // Access phase qualifiers
    logic access;
    logic wr_en;

    // Decoded read data and address hit
    logic [31:0] rd_data;
    logic        addr_ok;

    // Software-visible state
    logic [1:0]  led_reg;
    logic [15:0] trig_len;
    logic [num_cams-1:0] trig_mask;

    // Remaining cycles of the current one-shot
    logic [15:0] trig_cnt;

    // Link is up in L0 or L0s
    logic link_up;

    ////////////////////////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////////////////////////

    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;

    always_comb begin
        rd_data = '0;
        addr_ok = 1'b1;
        case (apb_req.paddr)
            reg_id:        rd_data = platform_id;
            reg_led:       rd_data[1:0] = led_reg;
            // Alarms in 1:0, link up in 2
            reg_status:    rd_data[num_alarms:0] = {link_up, alarms};
            reg_presence:  rd_data[num_slots-1:0] = presence;
            // Last fired mask
            reg_trig_fire: rd_data[num_cams-1:0] = trig_mask;
            reg_trig_len:  rd_data[15:0] = trig_len;
            default:       addr_ok = 1'b0;
        endcase
    end

    // No wait states
    assign apb_rsp.prdata  = rd_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & ~addr_ok;

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    // Writes land on the edge ending the access phase
    // ID, status and presence ignore writes
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            led_reg  <= '0;
            trig_len <= trig_len_rst;
        end else if (wr_en) begin
            if (apb_req.paddr == reg_led) begin
                led_reg <= apb_req.pwdata[1:0];
            end
            if (apb_req.paddr == reg_trig_len) begin
                trig_len <= apb_req.pwdata[15:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Camera one-shot
    ////////////////////////////////////////////////////////////

    // Fire loads the mask and the full length
    // A fire mid-pulse restarts with the new mask
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            trig_mask <= '0;
            trig_cnt  <= '0;
        end else if (wr_en && apb_req.paddr == reg_trig_fire) begin
            trig_mask <= apb_req.pwdata[num_cams-1:0];
            trig_cnt  <= trig_len;
        end else if (trig_cnt != '0) begin
            trig_cnt <= trig_cnt - 16'd1;
        end
    end

    // High for exactly trig_len cycles per fire
    assign cam_trigger = (trig_cnt != '0) ? trig_mask : '0;

    ////////////////////////////////////////////////////////////
    // LEDs
    ////////////////////////////////////////////////////////////

    assign link_up = (ltssm == ltssm_l0) || (ltssm == ltssm_l0s);

    // Active-low LEDs, bit 0 shows the link
    assign prog_led_n[0]   = ~link_up;
    assign prog_led_n[2:1] = ~led_reg;

endmodule

// ==== verilog/reset_sequencer.sv ====
module reset_sequencer (
    input  logic clk125,
    input  logic sys_rst_n,
    output logic core_rst_n,
    output logic slot_release
);

    import platform_pkg::*;

    // First synchronizer stage
    logic rst_meta;

    // Settle delay counter, saturates at settle_cycles
    logic [settle_cnt_w-1:0] settle_cnt;

    // Two-flop synchronizer
    // Assert async, release on clk125
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rst_meta   <= 1'b0;
            core_rst_n <= 1'b0;
        end else begin
            rst_meta   <= 1'b1;
            core_rst_n <= rst_meta;
        end
    end

    // Count only once the core is out of reset
    // Release the slots one edge after the counter saturates
    always_ff @(posedge clk125 or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            settle_cnt   <= '0;
            slot_release <= 1'b0;
        end else if (core_rst_n) begin
            if (settle_cnt == settle_cnt_w'(settle_cycles)) begin
                slot_release <= 1'b1;
            end else begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/slot_clock_manager.sv ====
module slot_clock_manager (
    input  logic                            clk125,
    input  logic                            core_rst_n,
    input  logic                            slot_release,
    input  logic [platform_pkg::num_slots-1:0] slot_present_n,
    output logic [platform_pkg::num_slots-1:0] presence,
    output logic [platform_pkg::num_slots-1:0] slot_clk,
    output logic [platform_pkg::num_slots-1:0] slot_clk_oe,
    output logic [platform_pkg::num_slots-1:0] clk_req_pull
);

    import platform_pkg::*;

    // Half-period counter for the sync divider
    logic [sync_cnt_w-1:0] sync_cnt;

    // Free-running 16 kHz sync clock
    logic sync_clk;

    ////////////////////////////////////////////////////////////
    // Board presence
    ////////////////////////////////////////////////////////////

    // Shared pins read as presence straps while in reset
    // Active-low strap, so invert into a present flag
    // Frozen once the core leaves reset
    always_ff @(posedge clk125) begin
        if (!core_rst_n) begin
            presence <= ~slot_present_n;
        end
    end

    ////////////////////////////////////////////////////////////
    // Sync clock divider
    ////////////////////////////////////////////////////////////

    // Toggle every sync_half_period cycles
    // Held at zero while the core is in reset
    always_ff @(posedge clk125 or negedge core_rst_n) begin
        if (!core_rst_n) begin
            sync_cnt <= '0;
            sync_clk <= 1'b0;
        end else if (sync_cnt == sync_cnt_w'(sync_half_period - 1)) begin
            sync_cnt <= '0;
            sync_clk <= ~sync_clk;
        end else begin
            sync_cnt <= sync_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Slot pin drive
    ////////////////////////////////////////////////////////////

    // Same sync phase on every present slot
    assign slot_clk = presence & {num_slots{sync_clk}};

    // Pins stay inputs until the settle delay ends
    assign slot_clk_oe = slot_release ? presence : '0;

    // Open-drain clock request, pull low for each present board
    assign clk_req_pull = presence;

endmodule

// ==== vlog.f ====
+incdir+tests
verilog/platform_pkg.sv
verilog/reset_sequencer.sv
verilog/input_debouncer.sv
verilog/slot_clock_manager.sv
verilog/platform_regs.sv
verilog/platform_ctrl_top.sv
tests/platform_ctrl_tb.sv
